/* hdl/arm_instr_pkg.sv */
`default_nettype none

package arm_instr_pkg;

    localparam int INSTR_W = 32;

    // Single load/store with bits 27:26 = 01
    typedef struct packed {
        logic [3:0]  cond;
        logic [1:0]  cls;
        logic        i;       // Register offset when set
        logic        p;
        logic        u;       // Add offset
        logic        b;       // Unsigned byte
        logic        w;
        logic        l;       // Load
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [11:0] offset;
    } ls_view_t;

    // Halfword, signed byte and doubleword transfers
    typedef struct packed {
        logic [3:0] cond;
        logic [2:0] cls;
        logic       p;
        logic       u;
        logic       i;        // Immediate offset when set
        logic       w;
        logic       l;
        logic [3:0] rn;
        logic [3:0] rd;
        logic [3:0] imm_hi;
        logic       bit7;
        logic       s;
        logic       h;
        logic       bit4;
        logic [3:0] imm_lo;
    } misc_view_t;

    typedef struct packed {
        logic [3:0]  cond;
        logic [1:0]  cls;
        logic        i;
        logic [3:0]  opcode;
        logic        s;       // Update flags
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [11:0] operand2;
    } dp_view_t;

    typedef struct packed {
        logic [3:0]  cond;
        logic [2:0]  cls;
        logic        l;       // Link
        logic [23:0] offset;
    } br_view_t;

    typedef union packed {
        ls_view_t   ls;
        misc_view_t misc;
        dp_view_t   dp;
        br_view_t   br;
    } instr_t;

    typedef enum logic [2:0] {
        CLS_LS_IMM,
        CLS_LS_REG,
        CLS_MISC_LS,
        CLS_DP,
        CLS_BRANCH,
        CLS_UNKNOWN
    } instr_class_t;

endpackage

`default_nettype wire

/* hdl/arm_state_encoder.sv */
`timescale 1ns/100ps
`default_nettype none

module arm_state_encoder #(
    parameter int INSTR_W = arm_instr_pkg::INSTR_W
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       instr_valid,
    input  logic [INSTR_W-1:0]         instr,
    output logic                       state_valid,
    output ctrl_state_pkg::state_num_t state_number
);

    logic                        dec_valid;
    arm_instr_pkg::instr_t       dec_instr;
    arm_instr_pkg::instr_class_t dec_class;
    ctrl_state_pkg::state_num_t  ls_state;

    instr_classify #(
        .INSTR_W (INSTR_W)
    ) classify_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .dec_instr   (dec_instr),
        .dec_class   (dec_class)
    );

    // Load/store lookup sits between the two register stages
    ls_state_table table_i (
        .dec_instr (dec_instr),
        .dec_class (dec_class),
        .ls_state  (ls_state)
    );

    state_select select_i (
        .clk          (clk),
        .rst          (rst),
        .dec_valid    (dec_valid),
        .dec_instr    (dec_instr),
        .dec_class    (dec_class),
        .ls_state     (ls_state),
        .state_valid  (state_valid),
        .state_number (state_number)
    );

endmodule

`default_nettype wire

/* hdl/ctrl_state_pkg.sv */
`default_nettype none

package ctrl_state_pkg;

    localparam int STATE_W = 10;

    typedef logic [STATE_W-1:0] state_num_t;

    localparam state_num_t STATE_FETCH = 10'd1;
    localparam state_num_t STATE_DP_S  = 10'd10;
    localparam state_num_t STATE_DP    = 10'd11;
    localparam state_num_t STATE_B     = 10'd12;
    localparam state_num_t STATE_BL    = 10'd13;

    // Addressing mode index into both tables
    localparam logic [1:0] ADDR_OFFSET = 2'd0;
    localparam logic [1:0] ADDR_PRE    = 2'd1;
    localparam logic [1:0] ADDR_POST   = 2'd2;

    // STRD has no misc operation index
    localparam int MISC_OPS = 5;

    localparam logic [2:0] MISC_STRH  = 3'd0;
    localparam logic [2:0] MISC_LDRD  = 3'd1;
    localparam logic [2:0] MISC_LDRH  = 3'd2;
    localparam logic [2:0] MISC_LDRSB = 3'd3;
    localparam logic [2:0] MISC_LDRSH = 3'd4;

    // Indexed [L][B][U][mode][register offset]
    localparam state_num_t LS_STATE_TABLE [2][2][2][3][2] = '{
        '{                                          // Store
            '{                                      // Word
                '{'{53, 54}, '{55, 56}, '{57, 60}}, // Subtract
                '{'{43, 44}, '{45, 46}, '{47, 50}}  // Add
            },
            '{                                      // Byte
                '{'{30, 31}, '{32, 33}, '{34, 37}},
                '{'{20, 21}, '{22, 23}, '{24, 27}}
            }
        },
        '{                                          // Load
            '{                                      // Word
                '{'{93, 94}, '{95, 96}, '{97, 99}},
                '{'{85, 86}, '{87, 88}, '{89, 91}}
            },
            '{                                      // Byte
                '{'{74, 75}, '{76, 77}, '{78, 80}},
                '{'{66, 67}, '{68, 69}, '{70, 72}}
            }
        }
    };

    // Indexed [operation][U][mode][register offset]
    localparam state_num_t MISC_STATE_TABLE [MISC_OPS][2][3][2] = '{
        '{                                          // STRH
            '{'{114, 115}, '{116, 117}, '{118, 121}},
            '{'{104, 105}, '{106, 107}, '{108, 111}}
        },
        '{                                          // LDRD
            '{'{192, 193}, '{194, 195}, '{196, 198}},
            '{'{184, 185}, '{186, 187}, '{188, 190}}
        },
        '{                                          // LDRH
            '{'{135, 136}, '{137, 138}, '{139, 141}},
            '{'{127, 128}, '{129, 130}, '{131, 133}}
        },
        '{                                          // LDRSB
            '{'{154, 155}, '{156, 157}, '{158, 160}},
            '{'{146, 147}, '{148, 149}, '{150, 152}}
        },
        '{                                          // LDRSH
            '{'{173, 174}, '{175, 176}, '{177, 179}},
            '{'{165, 166}, '{167, 168}, '{169, 171}}
        }
    };

endpackage

`default_nettype wire

/* hdl/instr_classify.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_classify #(
    parameter int INSTR_W = arm_instr_pkg::INSTR_W
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  logic [INSTR_W-1:0]          instr,
    output logic                        dec_valid,
    output arm_instr_pkg::instr_t       dec_instr,
    output arm_instr_pkg::instr_class_t dec_class
);

    arm_instr_pkg::instr_t       word;
    arm_instr_pkg::instr_class_t cls_next;

    assign word = instr;

    // First matching encoding space wins
    always_comb
    begin
        case (word.misc.cls)
            3'b010:
                cls_next = arm_instr_pkg::CLS_LS_IMM;
            3'b011:
                if (!word.misc.bit4)
                    cls_next = arm_instr_pkg::CLS_LS_REG;
                else
                    cls_next = arm_instr_pkg::CLS_UNKNOWN;  // Media space
            3'b000:
                if (word.misc.bit7 && word.misc.bit4)
                    cls_next = arm_instr_pkg::CLS_MISC_LS;
                else
                    cls_next = arm_instr_pkg::CLS_DP;
            3'b001:
                cls_next = arm_instr_pkg::CLS_DP;     // Immediate operand
            3'b101:
                cls_next = arm_instr_pkg::CLS_BRANCH;
            default:
                cls_next = arm_instr_pkg::CLS_UNKNOWN; // LDM/STM lands here too
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            dec_valid <= 1'b0;
        else
            dec_valid <= instr_valid;
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid)
        begin
            dec_instr <= word;
            dec_class <= cls_next;
        end
    end

    a_instr_known: assert property (
        @(posedge clk) disable iff (rst)
        instr_valid |-> !$isunknown(instr)
    ) else $error("instr has unknown bits while instr_valid is high");

endmodule

`default_nettype wire

/* hdl/ls_state_table.sv */
`timescale 1ns/100ps
`default_nettype none

module ls_state_table (
    input  arm_instr_pkg::instr_t       dec_instr,
    input  arm_instr_pkg::instr_class_t dec_class,
    output ctrl_state_pkg::state_num_t  ls_state
);

    logic [1:0] addr_mode;
    logic [2:0] misc_op;
    logic       misc_known;
    logic       ls_reg;
    logic       misc_reg;

    // P and W sit at the same bits in both load/store views
    always_comb
    begin
        if (!dec_instr.ls.p)
            addr_mode = ctrl_state_pkg::ADDR_POST;
        else if (dec_instr.ls.w)
            addr_mode = ctrl_state_pkg::ADDR_PRE;
        else
            addr_mode = ctrl_state_pkg::ADDR_OFFSET;
    end

    assign ls_reg   = (dec_class == arm_instr_pkg::CLS_LS_REG);
    assign misc_reg = !dec_instr.misc.i;

    // Operation from L, S and H
    always_comb
    begin
        misc_known = 1'b1;
        misc_op    = ctrl_state_pkg::MISC_STRH;
        case ({dec_instr.misc.l, dec_instr.misc.s, dec_instr.misc.h})
            3'b001:  misc_op = ctrl_state_pkg::MISC_STRH;
            3'b010:  misc_op = ctrl_state_pkg::MISC_LDRD;
            3'b101:  misc_op = ctrl_state_pkg::MISC_LDRH;
            3'b110:  misc_op = ctrl_state_pkg::MISC_LDRSB;
            3'b111:  misc_op = ctrl_state_pkg::MISC_LDRSH;
            default: misc_known = 1'b0;   // STRD or SH = 00
        endcase
    end

    always_comb
    begin
        ls_state = ctrl_state_pkg::STATE_FETCH;
        case (dec_class)
            arm_instr_pkg::CLS_LS_IMM,
            arm_instr_pkg::CLS_LS_REG:
            begin
                ls_state = ctrl_state_pkg::LS_STATE_TABLE[dec_instr.ls.l][dec_instr.ls.b]
                                                         [dec_instr.ls.u][addr_mode][ls_reg];
            end
            arm_instr_pkg::CLS_MISC_LS:
            begin
                if (misc_known)
                    ls_state = ctrl_state_pkg::MISC_STATE_TABLE[misc_op][dec_instr.misc.u]
                                                               [addr_mode][misc_reg];
            end
            default:
            begin
                ls_state = ctrl_state_pkg::STATE_FETCH;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/state_select.sv */
`timescale 1ns/100ps
`default_nettype none

module state_select (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dec_valid,
    input  arm_instr_pkg::instr_t       dec_instr,
    input  arm_instr_pkg::instr_class_t dec_class,
    input  ctrl_state_pkg::state_num_t  ls_state,
    output logic                        state_valid,
    output ctrl_state_pkg::state_num_t  state_number
);

    ctrl_state_pkg::state_num_t state_next;

    always_comb
    begin
        case (dec_class)
            arm_instr_pkg::CLS_LS_IMM,
            arm_instr_pkg::CLS_LS_REG,
            arm_instr_pkg::CLS_MISC_LS:
                state_next = ls_state;
            arm_instr_pkg::CLS_DP:
                state_next = dec_instr.dp.s ? ctrl_state_pkg::STATE_DP_S
                                            : ctrl_state_pkg::STATE_DP;
            arm_instr_pkg::CLS_BRANCH:
                state_next = dec_instr.br.l ? ctrl_state_pkg::STATE_BL
                                            : ctrl_state_pkg::STATE_B;
            default:
                state_next = ctrl_state_pkg::STATE_FETCH;   // Back to fetch
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_valid  <= 1'b0;
            state_number <= ctrl_state_pkg::STATE_FETCH;
        end
        else
        begin
            state_valid <= dec_valid;
            if (dec_valid)
                state_number <= state_next;   // Held between instructions
        end
    end

    // Single load/store words always find a table entry
    a_ls_entry: assert property (
        @(posedge clk) disable iff (rst)
        (dec_valid && (dec_class == arm_instr_pkg::CLS_LS_IMM ||
                       dec_class == arm_instr_pkg::CLS_LS_REG))
            |-> (ls_state != ctrl_state_pkg::STATE_FETCH)
    ) else $error("single load/store word mapped to the fetch state");

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_arm_state_encoder \
    -o sim_tb

# $fatal gives a nonzero status, so keep the output and decide below
output=$(./obj_dir/sim_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi

/* src.f */
+incdir+include
hdl/arm_instr_pkg.sv
hdl/ctrl_state_pkg.sv
hdl/instr_classify.sv
hdl/ls_state_table.sv
hdl/state_select.sv
hdl/arm_state_encoder.sv
testbench/tb_arm_state_encoder.sv

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Included inside the testbench module and uses its clk and state_valid

task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped on first error");
endtask

task automatic check_state(
    input ctrl_state_pkg::state_num_t actual,
    input ctrl_state_pkg::state_num_t expected,
    input string                      what
);
    string msg;
    if (actual !== expected)
    begin
        msg = $sformatf("%s: state_number is %0d, expected %0d", what, actual, expected);
        report_error(msg);
    end
endtask

task automatic check_valid(
    input logic  actual,
    input logic  expected,
    input string what
);
    string msg;
    if (actual !== expected)
    begin
        msg = $sformatf("%s: state_valid is %b, expected %b", what, actual, expected);
        report_error(msg);
    end
endtask

// Samples 1 ns after each rising edge like the stimulus
task automatic wait_state_valid(
    input  int    max_cycles,
    input  string what,
    output int    cycles
);
    bit seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < max_cycles)
    begin
        @(posedge clk);
        #1;
        cycles++;
        if (state_valid === 1'b1)
            seen = 1'b1;
    end
    if (!seen)
        report_error($sformatf("%s: state_valid never arrived within %0d cycles",
                               what, max_cycles));
endtask

// Latency count between strobe and response
task automatic expect_latency(
    input int    cycles,
    input int    expected,
    input string what
);
    if (cycles != expected)
        report_error($sformatf("%s: response after %0d cycles, expected %0d",
                               what, cycles, expected));
endtask

`endif

/* testbench/tb_arm_state_encoder.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_arm_state_encoder;

    logic                       clk;
    logic                       rst;
    logic                       instr_valid;
    logic [31:0]                instr;
    logic                       state_valid;
    ctrl_state_pkg::state_num_t state_number;

    // Register post-indexed numbers ordered store/load, then byte/word, then add/subtract
    localparam int LS_POST_REG [8] = '{27, 37, 50, 60, 72, 80, 91, 99};
    // STRH, LDRH, LDRSB, LDRSH, LDRD
    localparam int MISC_BASE [5] = '{104, 127, 146, 165, 184};
    localparam int MISC_POST_REG [10] = '{111, 133, 152, 171, 190, 121, 141, 160, 179, 198};

    arm_state_encoder #(
        .INSTR_W (32)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .state_valid  (state_valid),
        .state_number (state_number)
    );

    `include "tb_checks.svh"

    always #5 clk = ~clk;

    function automatic int ls_expected(
        input logic       l,
        input logic       b,
        input logic       u,
        input logic [1:0] mode,
        input logic       rg
    );
        int base;
        int idx;
        if (l)
            base = b ? 66 : 85;
        else
            base = b ? 20 : 43;
        idx  = (l ? 4 : 0) + (b ? 0 : 2) + (u ? 0 : 1);
        base = base + 2 * int'(mode);
        if (!u)
            base = base + (l ? 8 : 10);  // Subtract offset
        if (rg && mode == 2'd2)
            return LS_POST_REG[idx];
        return rg ? base + 1 : base;
    endfunction

    function automatic int misc_expected(
        input logic       l,
        input logic       s,
        input logic       h,
        input logic       u,
        input logic [1:0] mode,
        input logic       rg
    );
        int op;
        int base;
        case ({l, s, h})
            3'b001:  op = 0;    // STRH
            3'b101:  op = 1;    // LDRH
            3'b110:  op = 2;    // LDRSB
            3'b111:  op = 3;    // LDRSH
            3'b010:  op = 4;    // LDRD
            default: op = -1;   // STRD and SH = 00
        endcase
        if (op < 0)
            return 1;
        base = MISC_BASE[op] + 2 * int'(mode);
        if (!u)
            base = base + (op == 0 ? 10 : 8);
        if (rg && mode == 2'd2)
            return MISC_POST_REG[u ? op : op + 5];
        return rg ? base + 1 : base;
    endfunction

    // Full decode of any word for the random burst
    function automatic int expected_state(input logic [31:0] w);
        logic [1:0] mode;
        int         dp;
        mode = !w[24] ? 2'd2 : (w[21] ? 2'd1 : 2'd0);
        dp   = w[20] ? 10 : 11;
        case (w[27:25])
            3'b010:  return ls_expected(w[20], w[22], w[23], mode, 1'b0);
            3'b011:  return w[4] ? 1 : ls_expected(w[20], w[22], w[23], mode, 1'b1);
            3'b000:
                if (w[7] && w[4])
                    return misc_expected(w[20], w[6], w[5], w[23], mode, !w[22]);
                else
                    return dp;
            3'b001:  return dp;
            3'b101:  return w[24] ? 13 : 12;
            default: return 1;
        endcase
    endfunction

    // Strobe one word and check its response and the end of its pulse
    task automatic run_one(input logic [31:0] word, input int expected, input string what);
        int                         cycles;
        ctrl_state_pkg::state_num_t exp_num;
        exp_num     = expected[9:0];
        instr_valid = 1'b1;
        instr       = word;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        wait_state_valid(8, what, cycles);
        expect_latency(cycles + 1, 2, what);
        check_valid(state_valid, 1'b1, what);
        check_state(state_number, exp_num, what);
        @(posedge clk);
        #1;
        check_valid(state_valid, 1'b0, {what, " pulse end"});
    endtask

    task automatic after_reset();
        check_valid(state_valid, 1'b0, "after reset");
        check_state(state_number, 10'd1, "after reset");
        @(posedge clk);
        #1;
        // No word decoded yet and the number must hold
        check_valid(state_valid, 1'b0, "idle after reset");
        check_state(state_number, 10'd1, "idle after reset");
    endtask

    task automatic single_ls_sweep();
        logic [5:0]  c;
        logic [31:0] w;
        for (int i = 0; i < 64; i++)
        begin
            c = i[5:0];
            if (c[4:3] == 2'd3)
                continue;                    // Only three addressing modes
            w         = $urandom();
            w[27:25]  = c[5] ? 3'b011 : 3'b010;
            w[24]     = (c[4:3] != 2'd2);
            w[23]     = c[2];
            w[22]     = c[1];
            w[21]     = (c[4:3] == 2'd1);
            w[20]     = c[0];
            if (c[5])
                w[4] = 1'b0;
            run_one(w, ls_expected(c[0], c[1], c[2], c[4:3], c[5]), "single load/store");
        end
    endtask

    task automatic misc_ls_sweep();
        logic [6:0]  c;
        logic [31:0] w;
        for (int i = 0; i < 128; i++)
        begin
            c = i[6:0];
            if (c[5:4] == 2'd3)
                continue;
            w        = $urandom();
            w[27:25] = 3'b000;
            w[24]    = (c[5:4] != 2'd2);
            w[23]    = c[3];
            w[22]    = !c[6];                // I set means immediate
            w[21]    = (c[5:4] == 2'd1);
            w[20]    = c[2];
            w[7]     = 1'b1;
            w[6]     = c[1];
            w[5]     = c[0];
            w[4]     = 1'b1;
            run_one(w, misc_expected(c[2], c[1], c[0], c[3], c[5:4], c[6]), "misc load/store");
        end
    endtask

    task automatic other_classes();
        logic [31:0] w;
        for (int i = 0; i < 4; i++)
        begin
            w        = $urandom();
            w[27:26] = 2'b00;
            w[20]    = i[0];
            w[4]     = 1'b0;                 // Keeps out of the misc space
            run_one(w, i[0] ? 10 : 11, "data processing");
            w        = $urandom();
            w[27:25] = 3'b101;
            w[24]    = i[0];
            run_one(w, i[0] ? 13 : 12, "branch");
        end
        w        = $urandom();
        w[27:25] = 3'b100;
        run_one(w, 1, "load/store multiple");
        w[27:25] = 3'b110;
        run_one(w, 1, "coprocessor");
        w[27:25] = 3'b011;
        w[4]     = 1'b1;
        run_one(w, 1, "media");
    endtask

    // Back to back words with each response due two cycles after its strobe
    task automatic random_burst(input int count);
        logic [31:0]                words [$];
        logic [31:0]                w;
        int                         e;
        ctrl_state_pkg::state_num_t exp_num;
        for (int i = 0; i < count + 3; i++)
        begin
            if (i >= 2 && i < count + 2)
            begin
                e       = expected_state(words.pop_front());
                exp_num = e[9:0];
                check_valid(state_valid, 1'b1, "burst");
                check_state(state_number, exp_num, "burst");
            end
            else
                check_valid(state_valid, 1'b0, "burst idle");
            if (i < count)
            begin
                w = $urandom();
                case ($urandom() % 4)
                    0: w[27:26] = 2'b01;
                    1:
                    begin
                        w[27:25] = 3'b000;
                        w[7]     = 1'b1;
                        w[4]     = 1'b1;
                    end
                    2: w[27:25] = 3'b101;
                    default: ;                // Any class
                endcase
                words.push_back(w);
                instr_valid = 1'b1;
                instr       = w;
            end
            else
                instr_valid = 1'b0;
            @(posedge clk);
            #1;
        end
    endtask

    initial
    begin
        void'($urandom(7));
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        after_reset();
        single_ls_sweep();
        misc_ls_sweep();
        other_classes();
        random_burst(40);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
